// File: design/beat_tracker.sv
// Remaining narrow beat counter and running narrow address with wide word end detection
`timescale 1ns/1ns

module beat_tracker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  upsize_pkg::addr_t addr_i,
  input  upsize_pkg::len_t  len_i,
  input  upsize_pkg::size_t size_i,
  input  logic              beat_taken_i,
  output upsize_pkg::addr_t cur_addr_o,
  output upsize_pkg::size_t cur_size_o,
  output logic              last_beat_o,
  output logic              word_end_o,
  output logic              done_o
);
  import upsize_pkg::*;

  addr_t addr_q;
  addr_t next_addr;
  addr_t size_mask;
  len_t  cnt_q;
  size_t size_q;
  logic  active_q;

  // Next beat starts at the following size-aligned address
  assign size_mask = (addr_t'(1) << size_q) - addr_t'(1);
  assign next_addr = (addr_q & ~size_mask) + (addr_t'(1) << size_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      cnt_q    <= '0;
      size_q   <= '0;
      active_q <= 1'b0;
    end else if (start_i) begin
      addr_q   <= addr_i;
      cnt_q    <= len_i;
      size_q   <= size_i;
      active_q <= 1'b1;
    end else if (beat_taken_i) begin
      addr_q <= next_addr;
      if (cnt_q == '0) begin
        active_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - len_t'(1);
      end
    end
  end

  assign cur_addr_o  = addr_q;
  assign cur_size_o  = size_q;
  assign done_o      = !active_q;
  assign last_beat_o = active_q && (cnt_q == '0);

  // Ship the wide word when the next beat lands in another one
  assign word_end_o = last_beat_o ||
    (next_addr[ADDR_WIDTH-1:WIDE_OFFS_WIDTH] != addr_q[ADDR_WIDTH-1:WIDE_OFFS_WIDTH]);

  a_no_beat_when_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(beat_taken_i && done_o))
    else $error("Narrow beat accepted with no beats left in the burst");

endmodule

// File: design/lane_packer.sv
// Wide data and strobe register with narrow to wide byte lane steering
`timescale 1ns/1ns

module lane_packer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     pack_i,
  input  logic                     hdr_sent_i,
  input  upsize_pkg::addr_t        cur_addr_i,
  input  upsize_pkg::size_t        cur_size_i,
  input  logic                     last_beat_i,
  input  logic                     word_end_i,
  input  upsize_pkg::narrow_data_t slv_w_data_i,
  input  upsize_pkg::narrow_strb_t slv_w_strb_i,
  input  logic                     slv_w_valid_i,
  input  logic                     mst_w_ready_i,
  output logic                     slv_w_ready_o,
  output logic                     beat_taken_o,
  output upsize_pkg::wide_data_t   mst_w_data_o,
  output upsize_pkg::wide_strb_t   mst_w_strb_o,
  output logic                     mst_w_last_o,
  output logic                     mst_w_valid_o,
  output logic                     wide_xfer_last_o
);
  import upsize_pkg::*;

  logic [WIDE_BYTES-1:0] lane_en;
  addr_t                 size_mask, beat_end;
  wide_data_t            steer_data, data_q, data_d;
  wide_strb_t            steer_strb, strb_q, strb_d;
  logic                  valid_q, valid_d;
  logic                  last_q, last_d;
  logic                  wide_xfer;

  // Accept only while the wide register is empty or draining
  assign slv_w_ready_o = hdr_sent_i && (!valid_q || mst_w_ready_i);
  assign beat_taken_o  = slv_w_valid_i && slv_w_ready_o;
  assign wide_xfer     = valid_q && mst_w_ready_i;

  // --------------------------------------------------
  // Lane steering
  // --------------------------------------------------

  // Beat covers cur_addr up to the end of its size-aligned span
  assign size_mask = (addr_t'(1) << cur_size_i) - addr_t'(1);
  assign beat_end  = (cur_addr_i & ~size_mask) + (addr_t'(1) << cur_size_i);

  always_comb begin
    addr_t byte_addr;
    for (int w = 0; w < WIDE_BYTES; w++) begin
      byte_addr  = {cur_addr_i[ADDR_WIDTH-1:WIDE_OFFS_WIDTH], WIDE_OFFS_WIDTH'(w)};
      lane_en[w] = (byte_addr >= cur_addr_i) && (byte_addr < beat_end);
      steer_data[8*w +: 8] = slv_w_data_i[8*(w % NARROW_BYTES) +: 8];
      steer_strb[w]        = slv_w_strb_i[w % NARROW_BYTES];
    end
  end

  // --------------------------------------------------
  // Wide register
  // --------------------------------------------------

  always_comb begin
    data_d  = data_q;
    strb_d  = strb_q;
    valid_d = valid_q;
    last_d  = last_q;
    // Cleared on transfer so untouched lanes go out as zero
    if (wide_xfer) begin
      data_d  = '0;
      strb_d  = '0;
      valid_d = 1'b0;
      last_d  = 1'b0;
    end
    if (beat_taken_o) begin
      for (int w = 0; w < WIDE_BYTES; w++) begin
        if (lane_en[w]) begin
          data_d[8*w +: 8] = steer_data[8*w +: 8];
          strb_d[w]        = steer_strb[w];
        end
      end
      if (!pack_i || word_end_i) begin
        valid_d = 1'b1;
      end
      last_d = last_beat_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q  <= '0;
      strb_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      data_q  <= data_d;
      strb_q  <= strb_d;
      valid_q <= valid_d;
      last_q  <= last_d;
    end
  end

  assign mst_w_data_o     = data_q;
  assign mst_w_strb_o     = strb_q;
  assign mst_w_valid_o    = valid_q;
  assign mst_w_last_o     = last_q;
  assign wide_xfer_last_o = wide_xfer && last_q;

  a_w_data_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> $stable(mst_w_data_o))
    else $error("Wide write data changed while stalled");

endmodule

// File: design/upsize_pkg.sv
// Widths, field types, burst and FSM encodings, and lane constants for the write upsizer
package upsize_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  localparam int ADDR_WIDTH        = 16;
  localparam int NARROW_BYTES      = 4;
  localparam int WIDE_BYTES        = 8;
  localparam int NARROW_DATA_WIDTH = 8 * NARROW_BYTES;
  localparam int WIDE_DATA_WIDTH   = 8 * WIDE_BYTES;

  // Size code of a full wide beat
  localparam int WIDE_SIZE = 3;

  // --------------------------------------------------
  // Field types
  // --------------------------------------------------

  typedef logic [ADDR_WIDTH-1:0]        addr_t;
  typedef logic [7:0]                   len_t;
  typedef logic [2:0]                   size_t;
  typedef logic [3:0]                   cache_t;
  typedef logic [1:0]                   resp_t;
  typedef logic [NARROW_DATA_WIDTH-1:0] narrow_data_t;
  typedef logic [NARROW_BYTES-1:0]      narrow_strb_t;
  typedef logic [WIDE_DATA_WIDTH-1:0]   wide_data_t;
  typedef logic [WIDE_BYTES-1:0]        wide_strb_t;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } burst_t;

  // Write FSM modes
  typedef enum logic [1:0] {
    W_IDLE = 2'd0,
    W_PASS = 2'd1,
    W_PACK = 2'd2
  } w_state_t;

  // Bufferable/modifiable attribute bit
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // --------------------------------------------------
  // Lane constants
  // --------------------------------------------------

  localparam int    WIDE_OFFS_WIDTH = $clog2(WIDE_BYTES);
  localparam addr_t WIDE_MASK       = addr_t'(WIDE_BYTES - 1);

endpackage

// File: design/w_upsize_ctrl.sv
// Write burst FSM with outbound header register and packed length computation
`timescale 1ns/1ns

module w_upsize_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  upsize_pkg::addr_t  aw_addr_i,
  input  upsize_pkg::len_t   aw_len_i,
  input  upsize_pkg::size_t  aw_size_i,
  input  upsize_pkg::burst_t aw_burst_i,
  input  upsize_pkg::cache_t aw_cache_i,
  input  logic               aw_valid_i,
  input  logic               mst_aw_ready_i,
  input  logic               done_i,
  input  logic               wide_xfer_last_i,
  output logic               aw_ready_o,
  output upsize_pkg::addr_t  mst_aw_addr_o,
  output upsize_pkg::len_t   mst_aw_len_o,
  output upsize_pkg::size_t  mst_aw_size_o,
  output upsize_pkg::burst_t mst_aw_burst_o,
  output upsize_pkg::cache_t mst_aw_cache_o,
  output logic               mst_aw_valid_o,
  output logic               start_o,
  output logic               pack_o,
  output logic               hdr_sent_o
);
  import upsize_pkg::*;

  w_state_t state_q, state_d;
  logic     aw_valid_q, aw_valid_d;
  logic     hdr_sent_q, hdr_sent_d;
  logic     aw_hs;
  logic     upsize;
  addr_t    hdr_addr_q;
  len_t     hdr_len_q, hdr_len_d;
  size_t    hdr_size_q, hdr_size_d;
  burst_t   hdr_burst_q;
  cache_t   hdr_cache_q;
  addr_t    size_mask, addr_start, addr_end;

  assign aw_ready_o = (state_q == W_IDLE);
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign start_o    = aw_hs;
  assign upsize     = (aw_burst_i == INCR) && ((aw_cache_i & CACHE_MODIFIABLE) != '0);

  // --------------------------------------------------
  // Outbound header
  // --------------------------------------------------

  // Count of wide words touched between first and last narrow beat
  assign size_mask  = (addr_t'(1) << aw_size_i) - addr_t'(1);
  assign addr_start = aw_addr_i & ~WIDE_MASK;
  assign addr_end   = ((aw_addr_i & ~size_mask) + (addr_t'(aw_len_i) << aw_size_i)) & ~WIDE_MASK;
  assign hdr_len_d  = upsize ? len_t'((addr_end - addr_start) >> WIDE_SIZE) : aw_len_i;
  assign hdr_size_d = upsize ? size_t'(WIDE_SIZE) : aw_size_i;

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      hdr_addr_q  <= aw_addr_i;
      hdr_len_q   <= hdr_len_d;
      hdr_size_q  <= hdr_size_d;
      hdr_burst_q <= aw_burst_i;
      hdr_cache_q <= aw_cache_i;
    end
  end

  assign mst_aw_addr_o  = hdr_addr_q;
  assign mst_aw_len_o   = hdr_len_q;
  assign mst_aw_size_o  = hdr_size_q;
  assign mst_aw_burst_o = hdr_burst_q;
  assign mst_aw_cache_o = hdr_cache_q;
  assign mst_aw_valid_o = aw_valid_q;

  // --------------------------------------------------
  // Burst FSM
  // --------------------------------------------------

  always_comb begin
    state_d    = state_q;
    aw_valid_d = aw_valid_q;
    hdr_sent_d = hdr_sent_q;
    case (state_q)
      W_IDLE: begin
        if (aw_hs) begin
          state_d    = upsize ? W_PACK : W_PASS;
          aw_valid_d = 1'b1;
          hdr_sent_d = 1'b0;
        end
      end
      W_PASS, W_PACK: begin
        if (aw_valid_q && mst_aw_ready_i) begin
          aw_valid_d = 1'b0;
          hdr_sent_d = 1'b1;
        end
        // Burst ends with the last wide beat
        if (wide_xfer_last_i) begin
          state_d    = W_IDLE;
          hdr_sent_d = 1'b0;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= W_IDLE;
      aw_valid_q <= 1'b0;
      hdr_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      hdr_sent_q <= hdr_sent_d;
    end
  end

  assign pack_o = (state_q == W_PACK);

  // Data window closes once the tracker has seen every narrow beat
  assign hdr_sent_o = hdr_sent_q && !done_i;

  a_aw_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_addr_o))
    else $error("mst_aw_valid_o dropped or header changed before handshake");

endmodule

// File: design/w_upsizer_top.sv
// Write path upsizer top with controller, beat tracker, lane packer and response pass-through
`timescale 1ns/1ns

module w_upsizer_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Narrow side header
  input  upsize_pkg::addr_t        slv_aw_addr_i,
  input  upsize_pkg::len_t         slv_aw_len_i,
  input  upsize_pkg::size_t        slv_aw_size_i,
  input  upsize_pkg::burst_t       slv_aw_burst_i,
  input  upsize_pkg::cache_t       slv_aw_cache_i,
  input  logic                     slv_aw_valid_i,
  output logic                     slv_aw_ready_o,
  // Narrow side data
  input  upsize_pkg::narrow_data_t slv_w_data_i,
  input  upsize_pkg::narrow_strb_t slv_w_strb_i,
  input  logic                     slv_w_valid_i,
  output logic                     slv_w_ready_o,
  // Narrow side response
  output upsize_pkg::resp_t        slv_b_resp_o,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i,
  // Wide side header
  output upsize_pkg::addr_t        mst_aw_addr_o,
  output upsize_pkg::len_t         mst_aw_len_o,
  output upsize_pkg::size_t        mst_aw_size_o,
  output upsize_pkg::burst_t       mst_aw_burst_o,
  output upsize_pkg::cache_t       mst_aw_cache_o,
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  // Wide side data
  output upsize_pkg::wide_data_t   mst_w_data_o,
  output upsize_pkg::wide_strb_t   mst_w_strb_o,
  output logic                     mst_w_last_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  // Wide side response
  input  upsize_pkg::resp_t        mst_b_resp_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o
);
  import upsize_pkg::*;

  logic  start, pack, hdr_sent;
  logic  last_beat, word_end, done;
  logic  beat_taken, wide_xfer_last;
  addr_t cur_addr;
  size_t cur_size;

  w_upsize_ctrl ctrl_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .aw_addr_i        (slv_aw_addr_i),
    .aw_len_i         (slv_aw_len_i),
    .aw_size_i        (slv_aw_size_i),
    .aw_burst_i       (slv_aw_burst_i),
    .aw_cache_i       (slv_aw_cache_i),
    .aw_valid_i       (slv_aw_valid_i),
    .mst_aw_ready_i   (mst_aw_ready_i),
    .done_i           (done),
    .wide_xfer_last_i (wide_xfer_last),
    .aw_ready_o       (slv_aw_ready_o),
    .mst_aw_addr_o    (mst_aw_addr_o),
    .mst_aw_len_o     (mst_aw_len_o),
    .mst_aw_size_o    (mst_aw_size_o),
    .mst_aw_burst_o   (mst_aw_burst_o),
    .mst_aw_cache_o   (mst_aw_cache_o),
    .mst_aw_valid_o   (mst_aw_valid_o),
    .start_o          (start),
    .pack_o           (pack),
    .hdr_sent_o       (hdr_sent)
  );

  // Tracker follows the narrow burst as issued by the master
  beat_tracker tracker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .addr_i       (slv_aw_addr_i),
    .len_i        (slv_aw_len_i),
    .size_i       (slv_aw_size_i),
    .beat_taken_i (beat_taken),
    .cur_addr_o   (cur_addr),
    .cur_size_o   (cur_size),
    .last_beat_o  (last_beat),
    .word_end_o   (word_end),
    .done_o       (done)
  );

  lane_packer packer_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pack_i           (pack),
    .hdr_sent_i       (hdr_sent),
    .cur_addr_i       (cur_addr),
    .cur_size_i       (cur_size),
    .last_beat_i      (last_beat),
    .word_end_i       (word_end),
    .slv_w_data_i     (slv_w_data_i),
    .slv_w_strb_i     (slv_w_strb_i),
    .slv_w_valid_i    (slv_w_valid_i),
    .mst_w_ready_i    (mst_w_ready_i),
    .slv_w_ready_o    (slv_w_ready_o),
    .beat_taken_o     (beat_taken),
    .mst_w_data_o     (mst_w_data_o),
    .mst_w_strb_o     (mst_w_strb_o),
    .mst_w_last_o     (mst_w_last_o),
    .mst_w_valid_o    (mst_w_valid_o),
    .wide_xfer_last_o (wide_xfer_last)
  );

  // Response needs no conversion
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the write upsizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_w_upsizer -f sim.f -o tb_w_upsizer_sim

./obj_dir/tb_w_upsizer_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// File: sim.f
+incdir+test
design/upsize_pkg.sv
design/w_upsize_ctrl.sv
design/beat_tracker.sv
design/lane_packer.sv
design/w_upsizer_top.sv
test/tb_w_upsizer.sv

// File: test/tb_checks.svh
// Error counters and typed compare tasks for the write upsizer testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errs = 0;
int other_errs = 0;

task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
  value_errs++;
  $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_len(input string name, input len_t exp, input len_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_size(input string name, input size_t exp, input size_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_burst(input string name, input burst_t exp, input burst_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_cache(input string name, input cache_t exp, input cache_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_wide_data(input string name, input wide_data_t exp, input wide_data_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_wide_strb(input string name, input wide_strb_t exp, input wide_strb_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

task automatic check_resp(input string name, input resp_t exp, input resp_t act);
  if (act !== exp)
    report_value(name, 64'(exp), 64'(act));
endtask

`endif

// File: test/tb_w_upsizer.sv
// Testbench for the write upsizer with burst table, lane model, wide side stalls and response checks
`timescale 1ns/1ns

module tb_w_upsizer;
  import upsize_pkg::*;

  localparam int NUM_ROWS = 10;

  logic         clk_i;
  logic         rst_ni;
  addr_t        slv_aw_addr_i;
  len_t         slv_aw_len_i;
  size_t        slv_aw_size_i;
  burst_t       slv_aw_burst_i;
  cache_t       slv_aw_cache_i;
  logic         slv_aw_valid_i;
  logic         slv_aw_ready_o;
  narrow_data_t slv_w_data_i;
  narrow_strb_t slv_w_strb_i;
  logic         slv_w_valid_i;
  logic         slv_w_ready_o;
  resp_t        slv_b_resp_o;
  logic         slv_b_valid_o;
  logic         slv_b_ready_i;
  addr_t        mst_aw_addr_o;
  len_t         mst_aw_len_o;
  size_t        mst_aw_size_o;
  burst_t       mst_aw_burst_o;
  cache_t       mst_aw_cache_o;
  logic         mst_aw_valid_o;
  logic         mst_aw_ready_i;
  wide_data_t   mst_w_data_o;
  wide_strb_t   mst_w_strb_o;
  logic         mst_w_last_o;
  logic         mst_w_valid_o;
  logic         mst_w_ready_i;
  resp_t        mst_b_resp_i;
  logic         mst_b_valid_i;
  logic         mst_b_ready_o;

  integer seed;
  int     cycles = 0;
  int     limit = 0;

  // Burst table
  addr_t  row_addr     [NUM_ROWS];
  len_t   row_len      [NUM_ROWS];
  size_t  row_size     [NUM_ROWS];
  burst_t row_burst    [NUM_ROWS];
  cache_t row_cache    [NUM_ROWS];
  logic   row_stall    [NUM_ROWS];
  len_t   row_exp_len  [NUM_ROWS];
  size_t  row_exp_size [NUM_ROWS];

  // Narrow beats to drive and wide beats to expect for the current burst
  narrow_data_t beat_data_q[$];
  narrow_strb_t beat_strb_q[$];
  wide_data_t   exp_data_q[$];
  wide_strb_t   exp_strb_q[$];
  logic         exp_last_q[$];

  `include "tb_checks.svh"

  w_upsizer_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic set_row(input int r, input addr_t addr, input len_t len, input size_t size,
                         input burst_t burst, input cache_t cache, input logic stall,
                         input len_t exp_len, input size_t exp_size);
    row_addr[r]     = addr;
    row_len[r]      = len;
    row_size[r]     = size;
    row_burst[r]    = burst;
    row_cache[r]    = cache;
    row_stall[r]    = stall;
    row_exp_len[r]  = exp_len;
    row_exp_size[r] = exp_size;
  endtask

  task automatic fill_table();
    // row, addr, len, size, burst, cache, stall, outbound len, outbound size
    set_row(0, 16'h0000, 8'd7, 3'd2, INCR,  4'h2, 1'b0, 8'd3, 3'd3);
    set_row(1, 16'h0106, 8'd4, 3'd2, INCR,  4'h3, 1'b0, 8'd2, 3'd3);
    set_row(2, 16'h0202, 8'd6, 3'd1, INCR,  4'hf, 1'b0, 8'd1, 3'd3);
    set_row(3, 16'h0300, 8'd3, 3'd2, INCR,  4'h0, 1'b0, 8'd3, 3'd2);
    set_row(4, 16'h0404, 8'd2, 3'd2, FIXED, 4'h2, 1'b0, 8'd2, 3'd2);
    set_row(5, 16'h0500, 8'd3, 3'd1, WRAP,  4'h2, 1'b0, 8'd3, 3'd1);
    set_row(6, 16'h0106, 8'd4, 3'd2, INCR,  4'h3, 1'b1, 8'd2, 3'd3);
    set_row(7, 16'h0300, 8'd3, 3'd2, INCR,  4'h0, 1'b1, 8'd3, 3'd2);
    set_row(8, 16'h0601, 8'd9, 3'd0, INCR,  4'h2, 1'b1, 8'd1, 3'd3);
    set_row(9, 16'h0000, 8'd0, 3'd2, INCR,  4'h2, 1'b0, 8'd0, 3'd3);
  endtask

  function automatic logic rand_bit();
    integer v;
    v = $random(seed);
    return v[0];
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  task automatic build_expected(input int r);
    int           a;
    int           bytes;
    int           span_start;
    int           span_end;
    int           nbeats;
    logic         pack;
    narrow_data_t nd;
    narrow_strb_t ns;
    wide_data_t   data;
    wide_strb_t   strb;
    pack   = (row_burst[r] == INCR) && row_cache[r][1];
    nbeats = int'(row_len[r]) + 1;
    bytes  = 1 << row_size[r];
    a      = int'(row_addr[r]);
    data   = '0;
    strb   = '0;
    for (int k = 0; k < nbeats; k++) begin
      nd = narrow_data_t'($random(seed));
      ns = narrow_strb_t'($random(seed));
      beat_data_q.push_back(nd);
      beat_strb_q.push_back(ns);
      span_start = a - (a % bytes);
      span_end   = span_start + bytes;
      for (int b = a; b < span_end; b++) begin
        data[8*(b%8) +: 8] = nd[8*(b%4) +: 8];
        strb[b%8]          = ns[b%4];
      end
      // One wide beat per narrow beat, or per touched wide word when packing
      if (!pack || (k == nbeats - 1) || ((span_end / 8) != (a / 8))) begin
        exp_data_q.push_back(data);
        exp_strb_q.push_back(strb);
        exp_last_q.push_back(k == nbeats - 1);
        data = '0;
        strb = '0;
      end
      a = span_end;
    end
  endtask

  // --------------------------------------------------
  // Burst driver and wide side monitor
  // --------------------------------------------------

  task automatic run_burst(input int r);
    int   nbeats;
    int   sent;
    int   got;
    logic aw_pending;
    logic hdr_seen;
    logic last_seen;
    beat_data_q.delete();
    beat_strb_q.delete();
    build_expected(r);
    nbeats     = int'(row_len[r]) + 1;
    sent       = 0;
    got        = 0;
    aw_pending = 1'b1;
    hdr_seen   = 1'b0;
    last_seen  = 1'b0;
    while (!last_seen) begin
      @(negedge clk_i);
      slv_aw_valid_i = aw_pending;
      slv_aw_addr_i  = row_addr[r];
      slv_aw_len_i   = row_len[r];
      slv_aw_size_i  = row_size[r];
      slv_aw_burst_i = row_burst[r];
      slv_aw_cache_i = row_cache[r];
      slv_w_valid_i  = !aw_pending && (sent < nbeats);
      if (sent < nbeats) begin
        slv_w_data_i = beat_data_q[sent];
        slv_w_strb_i = beat_strb_q[sent];
      end
      mst_aw_ready_i = row_stall[r] ? rand_bit() : 1'b1;
      mst_w_ready_i  = row_stall[r] ? rand_bit() : 1'b1;
      #1;
      if (slv_aw_valid_i && slv_aw_ready_o)
        aw_pending = 1'b0;
      if (slv_w_valid_i && slv_w_ready_o) begin
        if (!hdr_seen) begin
          other_errs++;
          $display("Row %0d: narrow beat accepted before the outbound header", r);
        end
        sent++;
      end
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        hdr_seen = 1'b1;
        check_addr("mst_aw_addr_o", row_addr[r], mst_aw_addr_o);
        check_len("mst_aw_len_o", row_exp_len[r], mst_aw_len_o);
        check_size("mst_aw_size_o", row_exp_size[r], mst_aw_size_o);
        check_burst("mst_aw_burst_o", row_burst[r], mst_aw_burst_o);
        check_cache("mst_aw_cache_o", row_cache[r], mst_aw_cache_o);
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (exp_data_q.size() == 0) begin
          other_errs++;
          $display("Row %0d: wide beat beyond the expected count", r);
        end else begin
          check_wide_data("mst_w_data_o", exp_data_q.pop_front(), mst_w_data_o);
          check_wide_strb("mst_w_strb_o", exp_strb_q.pop_front(), mst_w_strb_o);
          check_bit("mst_w_last_o", exp_last_q.pop_front(), mst_w_last_o);
        end
        got++;
        if (mst_w_last_o)
          last_seen = 1'b1;
      end
    end
    if (!hdr_seen || sent != nbeats || exp_data_q.size() != 0) begin
      other_errs++;
      $display("Row %0d: burst ended with header, narrow beats or wide beats missing", r);
    end
    check_len("wide beat count minus one", row_exp_len[r], len_t'(got - 1));
  endtask

  // Response path is pure wiring in both directions
  task automatic check_response();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      mst_b_resp_i  = resp_t'(i);
      mst_b_valid_i = i[0];
      slv_b_ready_i = i[1];
      #1;
      check_resp("slv_b_resp_o", resp_t'(i), slv_b_resp_o);
      check_bit("slv_b_valid_o", i[0], slv_b_valid_o);
      check_bit("mst_b_ready_o", i[1], mst_b_ready_o);
    end
  endtask

  task automatic finish_run();
    $display("Closing: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, a burst did not complete", limit);
      other_errs++;
      finish_run();
    end
  end

  initial begin
    seed           = 64;
    rst_ni         = 1'b0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_aw_size_i  = '0;
    slv_aw_burst_i = FIXED;
    slv_aw_cache_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_resp_i   = '0;
    mst_b_valid_i  = 1'b0;
    fill_table();
    for (int r = 0; r < NUM_ROWS; r++)
      limit += 20 + 4 * (int'(row_len[r]) + 1);
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_bit("mst_aw_valid_o", 1'b0, mst_aw_valid_o);
    check_bit("mst_w_valid_o", 1'b0, mst_w_valid_o);
    check_bit("slv_w_ready_o", 1'b0, slv_w_ready_o);
    check_bit("slv_aw_ready_o", 1'b1, slv_aw_ready_o);
    check_response();
    for (int r = 0; r < NUM_ROWS; r++)
      run_burst(r);
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
    slv_w_valid_i  = 1'b0;
    finish_run();
  end

endmodule
